// File: list.f
hw/leaf_pkg.sv
hw/leaf_cfg_pkg.sv
hw/bft_rx.sv
hw/user_kernel.sv
hw/out_port.sv
hw/packet_arbiter.sv
hw/leaf_top.sv
tests/leaf_top_sva.sv
tests/leaf_top_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module leaf_top_tb

run: compile
	./obj_dir/Vleaf_top_tb > $(LOG) 2>&1 ; cat $(LOG)
	! grep -q "Testbench failed" $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/leaf_top_tb.sv
`timescale 1ns/100ps
`default_nettype none

module leaf_top_tb
    import leaf_pkg::*, leaf_cfg_pkg::*;
();

    localparam int CLK_PERIOD     = 20;
    localparam int TOTAL_WORDS    = 157;
    localparam int WORD_CYCLES    = 4;
    localparam int OTHER_CYCLES   = 200; // Reset, configs, filtering, resend hold, drains
    localparam int TIMEOUT_CYCLES = TOTAL_WORDS * WORD_CYCLES + OTHER_CYCLES + 300;
    localparam logic [31:0] SEED  = 32'h5130538d;

    logic     clk = 1'b0;
    logic     rst_n;
    packet_t  din;
    packet_t  dout;
    logic     resend;
    logic [31:0] lfsr = SEED;
    int       errors = 0;
    payload_t acc_model = '0;
    seq_t     seq_model [2] = '{'0, '0};
    leaf_t    dst_leaf [2] = '{'0, '0};
    port_t    dst_port [2] = '{'0, '0};
    packet_t  exp_q0 [$];
    packet_t  exp_q1 [$];

    leaf_top DUT (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic packet_t make_packet(input leaf_t l, input port_t p, input seq_t s,
                                            input payload_t d);
        packet_t pk;
        pk = '0;
        pk[VALID_POS] = 1'b1;
        pk[LEAF_LSB +: NUM_LEAF_BITS] = l;
        pk[PORT_LSB +: NUM_PORT_BITS] = p;
        pk[SEQ_LSB +: NUM_ADDR_BITS] = s;
        pk[PAYLOAD_BITS-1:0] = d;
        return pk;
    endfunction

    // Leaf and port together pick the expected queue
    function automatic logic [8:0] dest_of(input packet_t pk);
        return pk[PORT_LSB +: NUM_PORT_BITS + NUM_LEAF_BITS];
    endfunction

    function automatic payload_t random_word();
        payload_t w;
        w = '0;
        for (int i = 0; i < PAYLOAD_BITS; i++) begin
            w = {w[PAYLOAD_BITS-2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1); // Galois step
        end
        return w;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string name);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic drive_packet(input packet_t pk);
        @(negedge clk);
        din = pk;
        @(negedge clk);
        din = '0;
        repeat (WORD_CYCLES - 2) @(negedge clk);
    endtask

    task automatic send_data(input payload_t w);
        acc_model = acc_model + w; // Wraps at 32 bits
        exp_q0.push_back(make_packet(dst_leaf[0], dst_port[0], seq_model[0], acc_model));
        exp_q1.push_back(make_packet(dst_leaf[1], dst_port[1], seq_model[1], w));
        seq_model[0]++;
        seq_model[1]++;
        drive_packet(make_packet(LEAF_ID, DATA_PORT, '0, w));
    endtask

    task automatic send_config(input logic sel, input leaf_t l, input port_t p);
        payload_t cfg;
        cfg = '0;
        cfg[CFG_SEL_BIT] = sel;
        cfg[CFG_PORT_LSB +: NUM_PORT_BITS] = p;
        cfg[CFG_LEAF_LSB +: NUM_LEAF_BITS] = l;
        dst_leaf[sel] = l;
        dst_port[sel] = p;
        drive_packet(make_packet(LEAF_ID, CONFIG_PORT, '0, cfg));
    endtask

    task automatic wait_drain();
        while (exp_q0.size() != 0 || exp_q1.size() != 0) @(negedge clk);
        repeat (8) @(negedge clk); // Catch stray extra packets
    endtask

    always @(posedge clk) begin
        if (resend) begin
            check_value(dout, 64'd0, "dout_leaf_interface2bft during resend");
        end
        if (rst_n && dout[VALID_POS]) begin
            if (exp_q0.size() != 0 && dest_of(dout) == dest_of(exp_q0[0])) begin
                check_value(dout, exp_q0.pop_front(), "dout_leaf_interface2bft port 0");
            end else if (exp_q1.size() != 0 && dest_of(dout) == dest_of(exp_q1[0])) begin
                check_value(dout, exp_q1.pop_front(), "dout_leaf_interface2bft port 1");
            end else begin
                errors++;
                $display("Unexpected output packet %h at %0t ns", dout, $time);
            end
        end
    end

    task automatic idle_after_reset();
        repeat (10) begin
            @(negedge clk);
            check_value(dout, 64'd0, "dout_leaf_interface2bft");
        end
    endtask

    task automatic route_and_sum();
        send_config(1'b0, 5'd5, 4'd2);
        send_config(1'b1, 5'd9, 4'd7);
        for (int i = 1; i <= 8; i++) begin
            send_data(32'h11 * i);
        end
        wait_drain();
    endtask

    task automatic filter_packets();
        packet_t pk;
        drive_packet(make_packet(5'd4, DATA_PORT, '0, 32'h0000_dead)); // Other leaf
        drive_packet(make_packet(LEAF_ID, 4'd5, '0, 32'h0000_beef));   // Unused port
        pk = make_packet(LEAF_ID, DATA_PORT, '0, 32'h1234_5678);
        pk[VALID_POS] = 1'b0;
        drive_packet(pk);
        pk = make_packet(LEAF_ID, CONFIG_PORT, '0, 32'h0000_03ff); // Would retarget port 1
        pk[VALID_POS] = 1'b0;
        drive_packet(pk);
        repeat (10) @(negedge clk);
        send_data(32'h0000_0100);
        send_data(32'hffff_fff0);
        wait_drain();
    endtask

    task automatic hold_on_resend();
        send_data(random_word());
        repeat (2) @(negedge clk); // First packet now sits in the output register
        resend = 1'b1;
        repeat (2) send_data(random_word());
        repeat (10) @(negedge clk);
        resend = 1'b0;
        wait_drain();
    endtask

    task automatic random_burst();
        repeat (140) send_data(random_word());
        wait_drain();
    endtask

    task automatic retarget_port();
        send_config(1'b1, 5'd12, 4'd4);
        repeat (4) send_data(random_word());
        wait_drain();
    endtask

    initial begin
        din    = '0;
        resend = 1'b0;
        rst_n  = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        idle_after_reset();
        route_and_sum();
        filter_packets();
        hold_on_resend();
        random_burst();
        retarget_port();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/leaf_top_sva.sv
`timescale 1ns/100ps
`default_nettype none

module leaf_top_sva
    import leaf_pkg::*;
(
    input wire          clk,
    input wire          rst_n,
    input wire          resend,
    input wire packet_t dout_leaf_interface2bft,
    input wire [1:0]    grant,
    input wire          vld_interface2user,
    input wire          ack_user2interface,
    input wire [1:0]    vld_user2interface,
    input wire [1:0]    ack_interface2user
);

    assert property (@(posedge clk) resend |-> dout_leaf_interface2bft == '0)
        else $error("output not zero while resend is high");

    // Reset clears the output register on the next edge
    assert property (@(posedge clk) !rst_n |=> dout_leaf_interface2bft == '0)
        else $error("output not zero after reset");

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
        else $error("more than one grant in a cycle");

    assert property (@(posedge clk) disable iff (!rst_n)
                     ack_user2interface |-> vld_interface2user)
        else $error("kernel input ack without vld");

    assert property (@(posedge clk) disable iff (!rst_n)
                     (ack_interface2user & ~vld_user2interface) == 2'b00)
        else $error("out port ack without vld");

endmodule

bind leaf_top leaf_top_sva u_sva (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .resend                  (resend),
    .dout_leaf_interface2bft (dout_leaf_interface2bft),
    .grant                   (grant),
    .vld_interface2user      (vld_interface2user),
    .ack_user2interface      (ack_user2interface),
    .vld_user2interface      (vld_user2interface),
    .ack_interface2user      (ack_interface2user)
);

`default_nettype wire

// File: hw/leaf_top.sv
`timescale 1ns/100ps
`default_nettype none

module leaf_top
    import leaf_pkg::*, leaf_cfg_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire packet_t din_leaf_bft2interface,
    output packet_t      dout_leaf_interface2bft,
    input  wire          resend
);

    wire payload_t                     dout_leaf_interface2user;
    wire                               vld_interface2user;
    wire                               ack_user2interface;
    wire payload_t [NUM_OUT_PORTS-1:0] din_leaf_user2interface;
    wire [NUM_OUT_PORTS-1:0]           vld_user2interface;
    wire [NUM_OUT_PORTS-1:0]           ack_interface2user;
    wire                               cfg_we;
    wire                               cfg_sel;
    wire leaf_t                        cfg_leaf;
    wire port_t                        cfg_port;
    wire packet_t [NUM_OUT_PORTS-1:0]  pkt;
    wire [NUM_OUT_PORTS-1:0]           pkt_vld;
    wire [NUM_OUT_PORTS-1:0]           grant;

    bft_rx u_rx (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .cfg_we                   (cfg_we),
        .cfg_sel                  (cfg_sel),
        .cfg_leaf                 (cfg_leaf),
        .cfg_port                 (cfg_port)
    );

    user_kernel u_kernel (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

    for (genvar i = 0; i < NUM_OUT_PORTS; i++) begin : g_out
        out_port #(
            .PORT_INDEX (i)
        ) u_out (
            .clk      (clk),
            .rst_n    (rst_n),
            .din      (din_leaf_user2interface[i]),
            .vld      (vld_user2interface[i]),
            .ack      (ack_interface2user[i]),
            .cfg_we   (cfg_we),
            .cfg_sel  (cfg_sel),
            .cfg_leaf (cfg_leaf),
            .cfg_port (cfg_port),
            .pkt      (pkt[i]),
            .pkt_vld  (pkt_vld[i]),
            .grant    (grant[i])
        );
    end

    packet_arbiter u_arb (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .pkt                     (pkt),
        .pkt_vld                 (pkt_vld),
        .resend                  (resend),
        .grant                   (grant),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

// File: hw/packet_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module packet_arbiter
    import leaf_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire packet_t [1:0] pkt,
    input  wire [1:0]          pkt_vld,
    input  wire                resend,
    output logic [1:0]         grant,
    output packet_t            dout_leaf_interface2bft
);

    logic    last;   // Port granted most recently
    logic    sel;
    packet_t dout_q;

    always_comb begin
        grant = 2'b00;
        if (pkt_vld == 2'b11) begin
            sel = ~last; // Other port goes first
        end else begin
            sel = pkt_vld[1];
        end
        if (!resend) begin
            grant[sel] = pkt_vld[sel];
        end
    end

    // Registered packet is held through resend and sent after release
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout_q <= '0;
            last   <= 1'b0;
        end else if (!resend) begin
            if (grant != 2'b00) begin
                dout_q <= pkt[sel];
                last   <= sel;
            end else begin
                dout_q <= '0;
            end
        end
    end

    assign dout_leaf_interface2bft = resend ? '0 : dout_q;

endmodule

`default_nettype wire

// File: hw/out_port.sv
`timescale 1ns/100ps
`default_nettype none

module out_port
    import leaf_pkg::*, leaf_cfg_pkg::*;
#(
    parameter int PORT_INDEX = 0
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire payload_t din,
    input  wire           vld,
    output logic          ack,
    input  wire           cfg_we,
    input  wire           cfg_sel,
    input  wire leaf_t    cfg_leaf,
    input  wire port_t    cfg_port,
    output packet_t       pkt,
    output logic          pkt_vld,
    input  wire           grant
);

    payload_t                mem [OUT_DEPTH];
    logic [OUT_PTR_BITS-1:0] wr_ptr;
    logic [OUT_PTR_BITS-1:0] rd_ptr;
    logic [OUT_PTR_BITS:0]   count;
    leaf_t                   dst_leaf;
    port_t                   dst_port;
    seq_t                    seq;
    logic                    push;
    logic                    pop;

    assign ack     = vld && (count != (OUT_PTR_BITS+1)'(OUT_DEPTH));
    assign push    = vld && ack;
    assign pkt_vld = (count != '0);
    assign pop     = pkt_vld && grant;

    always_comb begin
        pkt                                = '0;
        pkt[VALID_POS]                     = pkt_vld;
        pkt[LEAF_LSB +: NUM_LEAF_BITS]     = dst_leaf;
        pkt[PORT_LSB +: NUM_PORT_BITS]     = dst_port;
        pkt[SEQ_LSB +: NUM_ADDR_BITS]      = seq;
        pkt[PAYLOAD_BITS-1:0]              = mem[rd_ptr];
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            seq      <= '0;
            dst_leaf <= '0;
            dst_port <= '0;
        end else begin
            if (cfg_we && (cfg_sel == 1'(PORT_INDEX))) begin // Own table entry
                dst_leaf <= cfg_leaf;
                dst_port <= cfg_port;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                seq    <= seq + 1'b1; // Wraps past 127
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/user_kernel.sv
`timescale 1ns/100ps
`default_nettype none

module user_kernel
    import leaf_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire payload_t       dout_leaf_interface2user,
    input  wire                 vld_interface2user,
    output logic                ack_user2interface,
    output payload_t [1:0]      din_leaf_user2interface,
    output logic [1:0]          vld_user2interface,
    input  wire [1:0]           ack_interface2user
);

    payload_t acc;      // Running sum, wraps at 32 bits
    payload_t word_q;   // Accepted input word
    logic     word_vld;
    payload_t sum;

    assign sum = acc + word_q;

    // Take a word only with both outputs and the stage free
    assign ack_user2interface = vld_interface2user && !word_vld &&
                                (vld_user2interface == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_vld           <= 1'b0;
            acc                <= '0;
            vld_user2interface <= 2'b00;
        end else begin
            word_vld <= ack_user2interface;
            if (word_vld) begin
                acc                <= sum;
                vld_user2interface <= 2'b11;
            end else begin
                vld_user2interface <= vld_user2interface & ~ack_interface2user;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ack_user2interface) begin
            word_q <= dout_leaf_interface2user;
        end
        if (word_vld) begin
            din_leaf_user2interface[0] <= sum;    // Running sum
            din_leaf_user2interface[1] <= word_q; // Copy
        end
    end

endmodule

`default_nettype wire

// File: hw/bft_rx.sv
`timescale 1ns/100ps
`default_nettype none

module bft_rx
    import leaf_pkg::*, leaf_cfg_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire packet_t din_leaf_bft2interface,
    output payload_t     dout_leaf_interface2user,
    output logic         vld_interface2user,
    input  wire          ack_user2interface,
    output logic         cfg_we,
    output logic         cfg_sel,
    output leaf_t        cfg_leaf,
    output port_t        cfg_port
);

    payload_t               mem [IN_DEPTH];
    logic [IN_PTR_BITS-1:0] wr_ptr;
    logic [IN_PTR_BITS-1:0] rd_ptr;
    logic [IN_PTR_BITS:0]   count;
    port_t                  in_port;
    payload_t               in_data;
    logic                   for_me;
    logic                   is_cfg;
    logic                   push;
    logic                   pop;

    assign in_port = din_leaf_bft2interface[PORT_LSB +: NUM_PORT_BITS];
    assign in_data = din_leaf_bft2interface[PAYLOAD_BITS-1:0];
    assign for_me  = din_leaf_bft2interface[VALID_POS] &&
                     (din_leaf_bft2interface[LEAF_LSB +: NUM_LEAF_BITS] == LEAF_ID);
    assign is_cfg  = for_me && (in_port == CONFIG_PORT);
    assign push    = for_me && (in_port == DATA_PORT) &&
                     (count != (IN_PTR_BITS+1)'(IN_DEPTH)); // Dropped when full
    assign pop     = vld_interface2user && ack_user2interface;

    assign vld_interface2user       = (count != '0);
    assign dout_leaf_interface2user = mem[rd_ptr]; // Head of queue

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Table write strobe, one cycle after the config packet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_we <= 1'b0;
        end else begin
            cfg_we <= is_cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (is_cfg) begin
            cfg_sel  <= in_data[CFG_SEL_BIT];
            cfg_leaf <= in_data[CFG_LEAF_LSB +: NUM_LEAF_BITS];
            cfg_port <= in_data[CFG_PORT_LSB +: NUM_PORT_BITS];
        end
    end

endmodule

`default_nettype wire

// File: hw/leaf_cfg_pkg.sv
`default_nettype none

package leaf_cfg_pkg;

    import leaf_pkg::*;

    localparam leaf_t LEAF_ID     = 5'd3;
    localparam port_t CONFIG_PORT = 4'd0; // Routing table writes
    localparam port_t DATA_PORT   = 4'd1; // Kernel input words

    localparam int NUM_OUT_PORTS = 2;
    localparam int IN_DEPTH      = 8;
    localparam int OUT_DEPTH     = 4;
    localparam int IN_PTR_BITS   = $clog2(IN_DEPTH);
    localparam int OUT_PTR_BITS  = $clog2(OUT_DEPTH);

    // Layout of a configuration payload
    localparam int CFG_SEL_BIT  = 0;
    localparam int CFG_PORT_LSB = 1;
    localparam int CFG_LEAF_LSB = 5;

endpackage

`default_nettype wire

// File: hw/leaf_pkg.sv
`default_nettype none

package leaf_pkg;

    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_ADDR_BITS = 7;

    // Packet fields from the payload upward
    localparam int SEQ_LSB     = PAYLOAD_BITS;
    localparam int PORT_LSB    = SEQ_LSB + NUM_ADDR_BITS;
    localparam int LEAF_LSB    = PORT_LSB + NUM_PORT_BITS;
    localparam int VALID_POS   = LEAF_LSB + NUM_LEAF_BITS;
    localparam int PACKET_BITS = VALID_POS + 1; // 49 bits on the network

    typedef logic [PACKET_BITS-1:0]   packet_t;
    typedef logic [PAYLOAD_BITS-1:0]  payload_t;
    typedef logic [NUM_LEAF_BITS-1:0] leaf_t;
    typedef logic [NUM_PORT_BITS-1:0] port_t;
    typedef logic [NUM_ADDR_BITS-1:0] seq_t;

endpackage

`default_nettype wire
